// ==== head_pkg.sv ====
`default_nettype none

package head_pkg;

  // Precision of a single activation lane
  localparam int DATA_WIDTH = 16;

  // Lanes per block, a 4 by 4 spatial parallelism flattened into one vector
  localparam int NUM_LANES = 16;

  // One block of activations as it moves through the reordering stage.
  // Lane 0 sits in the least significant bits of the packed vector.
  typedef struct packed {
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] lane;
  } block_t;

  // Default head count of the attention block
  localparam int DEFAULT_NUM_HEADS = 4;

  // Default number of blocks that make up one head within a group
  localparam int DEFAULT_BLOCKS_PER_HEAD = 3;

endpackage

`default_nettype wire

// ==== find_first_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module find_first_arbiter #(
  parameter int NUM_REQUESTERS = 4
) (
  input  logic [NUM_REQUESTERS-1:0]         request,
  output logic [NUM_REQUESTERS-1:0]         grant_oh,
  output logic [$clog2(NUM_REQUESTERS)-1:0] grant_bin
);

  localparam int BIN_W = $clog2(NUM_REQUESTERS);

  // Two's complement isolates the lowest set request bit.
  // With no request at all the sum wraps to zero and nothing is granted
  assign grant_oh = request & (~request + 1'b1);

  // Scan from the top down, so the last hit and thus the index is the lowest requester.
  // With no request the index reads as 0
  always_comb begin
    grant_bin = '0;
    for (int i = NUM_REQUESTERS - 1; i >= 0; i--) begin
      if (request[i]) begin
        grant_bin = BIN_W'(i);
      end
    end
  end

  // The one-hot grant and the binary index must describe the same requester
  always_comb begin
    assert ($onehot0(grant_oh) && ((grant_oh == '0) == (request == '0))
            && (grant_oh == '0 || grant_oh[grant_bin]))
      else $error("find_first_arbiter: grant is not one-hot or disagrees with index");
  end

endmodule

`default_nettype wire

// ==== head_split.sv ====
`timescale 1ns/1ps
`default_nettype none

module head_split #(
  parameter int NUM_HEADS       = head_pkg::DEFAULT_NUM_HEADS,
  parameter int BLOCKS_PER_HEAD = head_pkg::DEFAULT_BLOCKS_PER_HEAD
) (
  input  logic                 clk,
  input  logic                 rst,

  // Head-interleaved input stream
  input  head_pkg::block_t     in_block,
  input  logic                 in_valid,
  output logic                 in_ready,

  // Broadcast block with one valid bit per head FIFO
  output head_pkg::block_t     split_block,
  output logic [NUM_HEADS-1:0] split_valid,
  input  logic [NUM_HEADS-1:0] split_ready
);

  localparam int HEAD_W = $clog2(NUM_HEADS);

  // Head that the next incoming block belongs to
  logic [HEAD_W-1:0] head_idx;
  logic              accept;

  // A block is taken only when the FIFO of its own head has room
  assign in_ready = split_ready[head_idx];
  assign accept   = in_valid && in_ready;

  // The payload is wired to every FIFO unchanged.
  // Only the selected head sees a valid, so only that FIFO writes it
  assign split_block = in_block;

  always_comb begin
    split_valid = '0;
    split_valid[head_idx] = in_valid;
  end

  // Block j of a group maps to head j modulo NUM_HEADS.
  // Since a group is a whole multiple of NUM_HEADS blocks, a plain wrapping
  // counter stays aligned across group boundaries
  always_ff @(posedge clk) begin
    if (rst) begin
      head_idx <= '0;
    end else if (accept) begin
      if (head_idx == HEAD_W'(NUM_HEADS - 1)) begin
        head_idx <= '0;
      end else begin
        head_idx <= head_idx + 1'b1;
      end
    end
  end

  // A stalled block must stay offered and unchanged, or the retry would
  // write a different block into the head's FIFO
  assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable(in_block))
    else $error("head_split: input block dropped or changed while stalled");

endmodule

`default_nettype wire

// ==== head_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module head_fifo #(
  parameter int DEPTH = head_pkg::DEFAULT_BLOCKS_PER_HEAD
) (
  input  logic             clk,
  input  logic             rst,

  // Write side, fed by the splitter
  input  head_pkg::block_t wr_block,
  input  logic             wr_valid,
  output logic             wr_ready,

  // Read side, drained by the gather
  output head_pkg::block_t rd_block,
  output logic             rd_valid,
  input  logic             rd_ready
);

  // A depth of one still needs a one-bit pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  head_pkg::block_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Full and empty come straight from the occupancy count
  assign wr_ready = (count != CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  assign wr_en    = wr_valid && wr_ready;
  assign rd_en    = rd_valid && rd_ready;

  // Head entry is read directly from the array, giving one cycle from write to read
  assign rd_block = mem[rd_ptr];

  // Storage array, written only on an accepted transfer
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_block;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leave the occupancy unchanged
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // The write pointer leads the read pointer by the occupancy, modulo the depth.
  // An overflow or underflow slips the pointers against the count
  assert property (@(posedge clk) disable iff (rst)
    (int'(wr_ptr) + DEPTH - int'(rd_ptr)) % DEPTH == int'(count) % DEPTH)
    else $error("head_fifo: pointers disagree with the occupancy count");

endmodule

`default_nettype wire

// ==== self_attention_head_gather.sv ====
`timescale 1ns/1ps
`default_nettype none

module self_attention_head_gather #(
  parameter int NUM_HEADS       = head_pkg::DEFAULT_NUM_HEADS,
  parameter int BLOCKS_PER_HEAD = head_pkg::DEFAULT_BLOCKS_PER_HEAD
) (
  input  logic                                 clk,
  input  logic                                 rst,

  // One block per head, each from its own FIFO
  input  head_pkg::block_t [NUM_HEADS-1:0]     split_head_out,
  input  logic             [NUM_HEADS-1:0]     split_head_out_valid,
  output logic             [NUM_HEADS-1:0]     split_head_out_ready,

  // Head-major output stream
  output head_pkg::block_t                     updated_tokens,
  output logic                                 updated_tokens_valid,
  input  logic                                 updated_tokens_ready
);

  localparam int HEAD_W = $clog2(NUM_HEADS);
  localparam int CNT_W  = $clog2(BLOCKS_PER_HEAD + 1);

  // Blocks already passed on for each head in the current group
  logic [NUM_HEADS-1:0][CNT_W-1:0] block_counter;

  // Set for each head that has delivered its full share of the group
  logic [NUM_HEADS-1:0] heads_flushed;
  logic                 all_flushed;

  // Lowest head that still owes blocks, as one-hot and as an index
  logic [NUM_HEADS-1:0] head_flushing_oh;
  logic [HEAD_W-1:0]    head_flushing_idx;

  // Each head is judged on its own counter
  for (genvar head = 0; head < NUM_HEADS; head++) begin : g_count
    assign heads_flushed[head] = (block_counter[head] == CNT_W'(BLOCKS_PER_HEAD));

    always_ff @(posedge clk) begin
      if (rst) begin
        block_counter[head] <= '0;
      end else if (all_flushed) begin
        // Group finished, so every head starts over in this one bubble cycle
        block_counter[head] <= '0;
      end else if (split_head_out_valid[head] && split_head_out_ready[head]) begin
        // Count up to the share of the group and hold there
        block_counter[head] <= heads_flushed[head] ? block_counter[head]
                                                   : block_counter[head] + 1'b1;
      end
    end
  end

  assign all_flushed = &heads_flushed;

  // Unfinished heads request, and the lowest one gets the output
  find_first_arbiter #(
    .NUM_REQUESTERS (NUM_HEADS)
  ) ff_arb_i (
    .request   (~heads_flushed),
    .grant_oh  (head_flushing_oh),
    .grant_bin (head_flushing_idx)
  );

  // Payload follows the chosen head with no register in between
  assign updated_tokens = split_head_out[head_flushing_idx];

  // With every head flushed the grant is empty.
  // That keeps valid low and all readies low for the clearing cycle
  assign updated_tokens_valid = |(split_head_out_valid & head_flushing_oh);
  assign split_head_out_ready = head_flushing_oh & {NUM_HEADS{updated_tokens_ready}};

  // A stalled output must hold its block until it is taken.
  // This relies on the FIFO head entry and the choice of head both standing still
  assert property (@(posedge clk) disable iff (rst)
    updated_tokens_valid && !updated_tokens_ready
      |=> updated_tokens_valid && $stable(updated_tokens))
    else $error("self_attention_head_gather: output changed under back-pressure");

endmodule

`default_nettype wire

// ==== head_reorder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module head_reorder_top #(
  parameter int NUM_HEADS       = head_pkg::DEFAULT_NUM_HEADS,
  parameter int BLOCKS_PER_HEAD = head_pkg::DEFAULT_BLOCKS_PER_HEAD
) (
  input  logic             clk,
  input  logic             rst,

  // Head-interleaved input
  input  head_pkg::block_t in_block,
  input  logic             in_valid,
  output logic             in_ready,

  // Head-major output
  output head_pkg::block_t out_block,
  output logic             out_valid,
  input  logic             out_ready
);

  // Splitter to FIFOs
  head_pkg::block_t                 split_block;
  logic             [NUM_HEADS-1:0] split_valid;
  logic             [NUM_HEADS-1:0] split_ready;

  // FIFOs to gather
  head_pkg::block_t [NUM_HEADS-1:0] fifo_block;
  logic             [NUM_HEADS-1:0] fifo_valid;
  logic             [NUM_HEADS-1:0] fifo_ready;

  // Steers every incoming block towards the FIFO of its head
  head_split #(
    .NUM_HEADS       (NUM_HEADS),
    .BLOCKS_PER_HEAD (BLOCKS_PER_HEAD)
  ) head_split_i (
    .clk         (clk),
    .rst         (rst),
    .in_block    (in_block),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .split_block (split_block),
    .split_valid (split_valid),
    .split_ready (split_ready)
  );

  // One FIFO per head, each deep enough for that head's share of a group
  for (genvar head = 0; head < NUM_HEADS; head++) begin : g_fifo
    head_fifo #(
      .DEPTH (BLOCKS_PER_HEAD)
    ) head_fifo_i (
      .clk      (clk),
      .rst      (rst),
      .wr_block (split_block),
      .wr_valid (split_valid[head]),
      .wr_ready (split_ready[head]),
      .rd_block (fifo_block[head]),
      .rd_valid (fifo_valid[head]),
      .rd_ready (fifo_ready[head])
    );
  end

  // Drains the FIFOs head by head
  self_attention_head_gather #(
    .NUM_HEADS       (NUM_HEADS),
    .BLOCKS_PER_HEAD (BLOCKS_PER_HEAD)
  ) gather_i (
    .clk                  (clk),
    .rst                  (rst),
    .split_head_out       (fifo_block),
    .split_head_out_valid (fifo_valid),
    .split_head_out_ready (fifo_ready),
    .updated_tokens       (out_block),
    .updated_tokens_valid (out_valid),
    .updated_tokens_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== tb_head_reorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_head_reorder;

  localparam int NUM_HEADS       = head_pkg::DEFAULT_NUM_HEADS;
  localparam int BLOCKS_PER_HEAD = head_pkg::DEFAULT_BLOCKS_PER_HEAD;
  localparam int GROUP_BLOCKS    = NUM_HEADS * BLOCKS_PER_HEAD;
  localparam int LANE_W          = head_pkg::DATA_WIDTH;
  localparam int VAL_W           = $bits(head_pkg::block_t);

  // Blocks over all tests: 1, 4, 3 and 2 groups
  localparam int TOTAL_BLOCKS   = GROUP_BLOCKS * 10;
  localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * 20 + 1000;

  // How out_ready behaves on each cycle
  localparam int READY_HIGH   = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_RANDOM = 2;

  logic             clk;
  logic             rst;
  head_pkg::block_t in_block;
  logic             in_valid;
  logic             in_ready;
  head_pkg::block_t out_block;
  logic             out_valid;
  logic             out_ready;

  // Reference model, one queue of pending blocks per head
  head_pkg::block_t head_q [NUM_HEADS][$];

  int    in_count;
  int    out_count;
  int    ready_mode;
  int    error_count;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;
  string test_name;

  head_reorder_top #(
    .NUM_HEADS       (NUM_HEADS),
    .BLOCKS_PER_HEAD (BLOCKS_PER_HEAD)
  ) head_reorder_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_block  (in_block),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_block (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [VAL_W-1:0] expected,
                             input logic [VAL_W-1:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      error_count++;
    end
  endtask

  // Advance to the next falling edge and update out_ready there.
  // All stimulus flows through this one process, so random draws stay in a fixed order
  task automatic step();
    @(negedge clk);
    case (ready_mode)
      READY_HIGH: out_ready = 1'b1;
      READY_LOW:  out_ready = 1'b0;
      default:    out_ready = ($urandom % 100) < 60;
    endcase
  endtask

  function automatic head_pkg::block_t random_block();
    head_pkg::block_t blk;
    for (int l = 0; l < head_pkg::NUM_LANES; l++) begin
      blk.lane[l] = LANE_W'($urandom);
    end
    return blk;
  endfunction

  // Input block j goes to head j modulo NUM_HEADS.
  // Groups are whole rounds over the heads, so a running count gives the head
  task automatic record_input(input head_pkg::block_t blk);
    head_q[in_count % NUM_HEADS].push_back(blk);
    in_count++;
  endtask

  // Present a block from a falling edge and hold it until in_ready is seen.
  // Returns on the falling edge after the accepting rising edge, with in_valid still high
  task automatic send_block(input head_pkg::block_t blk);
    in_block = blk;
    in_valid = 1'b1;
    #1;
    while (!in_ready) begin
      step();
      #1;
    end
    record_input(blk);
    step();
  endtask

  // Wait until every accepted block has left, then watch a while for strays
  task automatic wait_drain();
    while (out_count != in_count) begin
      step();
    end
    repeat (2 * GROUP_BLOCKS) step();
    check_value({test_name, " output count"}, VAL_W'(in_count), VAL_W'(out_count));
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic end_test();
    if (error_count == test_errors) begin
      $display("%s: ok", test_name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", test_name, error_count - test_errors);
      tests_failed++;
    end
  endtask

  // Output side of the model, sampled two ns after the falling edge when all is settled.
  // Output k of a group belongs to head k / BLOCKS_PER_HEAD
  always begin : output_monitor
    int               exp_head;
    head_pkg::block_t exp_blk;
    @(negedge clk);
    #2;
    if (!rst && out_valid && out_ready) begin
      exp_head = (out_count % GROUP_BLOCKS) / BLOCKS_PER_HEAD;
      if (head_q[exp_head].size() == 0) begin
        $display("ERROR: %s: an output block came out with no block pending for head %0d",
                 test_name, exp_head);
        error_count++;
      end else begin
        exp_blk = head_q[exp_head].pop_front();
        check_value({test_name, " out_block"}, exp_blk, out_block);
      end
      out_count++;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  task automatic test_reset_state();
    begin_test("test_reset_state");
    #1;
    check_value({test_name, " out_valid"}, VAL_W'(1'b0), VAL_W'(out_valid));
    check_value({test_name, " in_ready"}, VAL_W'(1'b1), VAL_W'(in_ready));
    step();
    end_test();
  endtask

  task automatic test_single_group();
    begin_test("test_single_group");
    ready_mode = READY_HIGH;
    step();
    for (int i = 0; i < GROUP_BLOCKS; i++) begin
      send_block(random_block());
      in_valid = 1'b0;
    end
    wait_drain();
    end_test();
  endtask

  // in_valid stays high across all four groups and the bubbles between them
  task automatic test_back_to_back_groups();
    begin_test("test_back_to_back_groups");
    ready_mode = READY_HIGH;
    step();
    for (int i = 0; i < 4 * GROUP_BLOCKS; i++) begin
      send_block(random_block());
    end
    in_valid = 1'b0;
    wait_drain();
    end_test();
  endtask

  task automatic test_random_backpressure();
    int gap;
    begin_test("test_random_backpressure");
    ready_mode = READY_RANDOM;
    step();
    for (int i = 0; i < 3 * GROUP_BLOCKS; i++) begin
      send_block(random_block());
      // About one block in four is followed by an idle gap of one to three cycles
      if ($urandom % 4 == 0) begin
        gap      = 1 + int'($urandom % 3);
        in_valid = 1'b0;
        repeat (gap) step();
      end
    end
    in_valid = 1'b0;
    ready_mode = READY_HIGH;
    wait_drain();
    end_test();
  endtask

  task automatic test_full_stall();
    int               rose;
    head_pkg::block_t stalled;
    begin_test("test_full_stall");
    rose       = 0;
    ready_mode = READY_LOW;
    step();
    // One full group fits, since every FIFO holds one head's share
    for (int i = 0; i < GROUP_BLOCKS; i++) begin
      send_block(random_block());
    end
    stalled  = random_block();
    in_block = stalled;
    in_valid = 1'b1;
    // Any accept here would mean more than one group got in
    repeat (20) begin
      #1;
      if (in_ready) begin
        rose++;
      end
      step();
    end
    if (rose != 0) begin
      $display("ERROR: %s: in_ready rose on %0d cycles while the output was stalled",
               test_name, rose);
      error_count++;
    end
    // The oldest block of head 0 must still be on offer at the output
    check_value({test_name, " out_valid while stalled"}, VAL_W'(1'b1), VAL_W'(out_valid));
    check_value({test_name, " out_block while stalled"}, head_q[0][0], out_block);
    // Release the output, then finish the stalled group
    ready_mode = READY_HIGH;
    send_block(stalled);
    for (int i = 1; i < GROUP_BLOCKS; i++) begin
      send_block(random_block());
    end
    in_valid = 1'b0;
    wait_drain();
    end_test();
  endtask

  initial begin
    void'($urandom(32'hea35));
    rst          = 1'b1;
    in_block     = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    ready_mode   = READY_HIGH;
    in_count     = 0;
    out_count    = 0;
    error_count  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_single_group();
    test_back_to_back_groups();
    test_random_backpressure();
    test_full_stall();

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
head_pkg.sv
find_first_arbiter.sv
head_split.sv
head_fifo.sv
self_attention_head_gather.sv
head_reorder_top.sv
tb_head_reorder.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the head reorder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_head_reorder \
  -f compile.f \
  -o tb_head_reorder

# The log decides the result, so a nonzero exit of the simulator is not fatal here
./obj_dir/tb_head_reorder > sim.log 2>&1 || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
